/* rtl/tau_pkg.sv */
// tile accelerator shared definitions
package tau_pkg;

	// ==================================================
	// widths and sizes
	// ==================================================
	localparam int WBW = 8;        // grid coordinate width
	localparam int GBW = 16;       // dram word address width
	localparam int DBW = 16;       // data word width
	localparam int CSIZE = 4;      // words per dram line, also lane mask width
	localparam int VDIM = 2;       // grid dimensions, 0 is x and 1 is y

	// default tile count, the top level hands it down as N_TAU
	localparam int N_TAU_DEF = 2;

	// ==================================================
	// lane operation of a job
	// ==================================================
	typedef enum logic [1:0] {
		OP_PASS = 2'd0, // copy the word
		OP_ADD  = 2'd1, // word + const, wraps at DBW
		OP_MAX  = 2'd2  // unsigned max of word and const
	} op_e;

	// ==================================================
	// state machines
	// ==================================================

	// block looper
	typedef enum logic [1:0] {
		IDLE  = 2'd0, // waiting for a job
		RUN   = 2'd1, // offering block offsets
		DRAIN = 2'd2  // grid done, waiting on blkdone
	} looper_state_e;

	// shared by the tile stages
	typedef enum logic [1:0] {
		EMPTY = 2'd0,
		REQ   = 2'd1, // address out to dram
		WAIT  = 2'd2  // waiting for the line
	} tile_state_e;

endpackage

/* rtl/block_looper.sv */
// block grid looper
module block_looper #(
	parameter int N_TAU = tau_pkg::N_TAU_DEF
) (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic                    i_src_rdy,
	output logic                    o_src_ack,
	input  logic [tau_pkg::WBW-1:0] i_bgrid_step [tau_pkg::VDIM],
	input  logic [tau_pkg::WBW-1:0] i_bgrid_end  [tau_pkg::VDIM],
	output logic [N_TAU-1:0]        o_bofs_rdy,
	input  logic [N_TAU-1:0]        i_bofs_ack,
	output logic [tau_pkg::WBW-1:0] o_bofs_x,
	output logic [tau_pkg::WBW-1:0] o_bofs_y,
	input  logic [N_TAU-1:0]        i_blkdone,
	output logic                    o_job_done
);
	import tau_pkg::*;

	localparam int PBW = (N_TAU > 1) ? $clog2(N_TAU) : 1;
	localparam int OBW = $clog2(6*N_TAU+1); // covers every block a tile can hold

	looper_state_e  state;
	logic [WBW-1:0] bx, by;
	logic [PBW-1:0] ptr;     // round-robin tile
	logic [OBW-1:0] n_out;   // dispatched, not yet done
	logic [OBW-1:0] n_done, n_out_nxt;
	logic [WBW:0]   x_nxt, y_nxt;
	logic           dispatch, x_wrap, y_last, grid_empty;

	assign o_src_ack = i_src_rdy && (state == IDLE); // job taken in the same cycle
	assign dispatch  = (state == RUN) && i_bofs_ack[ptr];

	// only the pointed tile is offered the block
	always_comb begin
		o_bofs_rdy = '0;
		if (state == RUN)
			o_bofs_rdy[ptr] = 1'b1;
	end
	assign o_bofs_x = bx;
	assign o_bofs_y = by;

	// ==================================================
	// grid stepping
	// ==================================================
	assign x_nxt  = {1'b0, bx} + {1'b0, i_bgrid_step[0]};
	assign y_nxt  = {1'b0, by} + {1'b0, i_bgrid_step[1]};
	assign x_wrap = x_nxt >= {1'b0, i_bgrid_end[0]};
	assign y_last = y_nxt >= {1'b0, i_bgrid_end[1]};
	assign grid_empty = (i_bgrid_end[0] == '0) || (i_bgrid_end[1] == '0);

	// several tiles may finish in one cycle
	always_comb begin
		n_done = '0;
		for (int t = 0; t < N_TAU; t++)
			n_done = n_done + OBW'(i_blkdone[t]);
	end
	assign n_out_nxt = n_out + OBW'(dispatch) - n_done;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state      <= IDLE;
			bx         <= '0;
			by         <= '0;
			ptr        <= '0;
			n_out      <= '0;
			o_job_done <= 1'b0;
		end else begin
			o_job_done <= 1'b0;
			n_out      <= n_out_nxt;
			case (state)
				IDLE: if (o_src_ack) begin
					bx    <= '0;
					by    <= '0;
					ptr   <= '0;
					state <= grid_empty ? DRAIN : RUN;
				end
				RUN: if (dispatch) begin
					ptr <= (ptr == PBW'(N_TAU-1)) ? '0 : ptr + 1'b1;
					if (!x_wrap) begin
						bx <= x_nxt[WBW-1:0];
					end else begin
						bx <= '0;
						by <= y_nxt[WBW-1:0];
						if (y_last)
							state <= DRAIN; // last block just left
					end
				end
				DRAIN: if (n_out_nxt == '0) begin
					o_job_done <= 1'b1;
					state      <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* rtl/tile_addr_gen.sv */
// tile address and mask generation
module tile_addr_gen (
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	input  logic                      i_bofs_rdy,
	output logic                      o_bofs_ack,
	input  logic [tau_pkg::WBW-1:0]   i_bofs_x,
	input  logic [tau_pkg::WBW-1:0]   i_bofs_y,
	input  logic [tau_pkg::WBW-1:0]   i_bboundary_x,
	input  logic [tau_pkg::GBW-1:0]   i_in_base,
	input  logic [tau_pkg::GBW-1:0]   i_out_base,
	input  logic [tau_pkg::GBW-1:0]   i_row_pitch,
	output logic                      o_ag_rdy,
	input  logic                      i_ag_ack,
	output logic [tau_pkg::GBW-1:0]   o_raddr,
	output logic [tau_pkg::GBW-1:0]   o_waddr,
	output logic [tau_pkg::CSIZE-1:0] o_mask
);
	import tau_pkg::*;

	logic [GBW-1:0]   lin;   // y*pitch + x
	logic [CSIZE-1:0] mask;

	// one entry, refilled in the cycle it drains
	assign o_bofs_ack = i_bofs_rdy && (!o_ag_rdy || i_ag_ack);

	assign lin = GBW'(i_bofs_y) * i_row_pitch + GBW'(i_bofs_x);

	// lane k sits on column x+k
	always_comb begin
		logic [WBW:0] col;
		for (int k = 0; k < CSIZE; k++) begin
			col     = {1'b0, i_bofs_x} + (WBW+1)'(k);
			mask[k] = col < {1'b0, i_bboundary_x};
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_ag_rdy <= 1'b0;
		else if (o_bofs_ack)
			o_ag_rdy <= 1'b1;
		else if (i_ag_ack)
			o_ag_rdy <= 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (o_bofs_ack) begin
			o_raddr <= i_in_base + lin;
			o_waddr <= i_out_base + lin;
			o_mask  <= mask;
		end
	end

endmodule

/* rtl/tile_alu.sv */
// tile line read and lane operation
module tile_alu (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  logic                              i_ag_rdy,
	output logic                              o_ag_ack,
	input  logic [tau_pkg::GBW-1:0]           i_raddr,
	input  logic [tau_pkg::GBW-1:0]           i_waddr,
	input  logic [tau_pkg::CSIZE-1:0]         i_mask,
	input  tau_pkg::op_e                      i_op,
	input  logic [tau_pkg::DBW-1:0]           i_const,
	output logic                              o_dramra_rdy,
	input  logic                              i_dramra_ack,
	output logic [tau_pkg::GBW-1:0]           o_dramra,
	input  logic                              i_dramrd_rdy,
	output logic                              o_dramrd_ack,
	input  logic [tau_pkg::CSIZE*tau_pkg::DBW-1:0] i_dramrd,
	output logic                              o_alu_rdy,
	input  logic                              i_alu_ack,
	output logic [tau_pkg::GBW-1:0]           o_waddr,
	output logic [tau_pkg::CSIZE*tau_pkg::DBW-1:0] o_wdata,
	output logic [tau_pkg::CSIZE-1:0]         o_wmask
);
	import tau_pkg::*;

	tile_state_e        state;
	logic [GBW-1:0]     req_waddr;  // travels with the read request
	logic [CSIZE-1:0]   req_mask;
	logic [CSIZE*DBW-1:0] line;

	function automatic logic [DBW-1:0] lane_op(op_e op, logic [DBW-1:0] d, logic [DBW-1:0] c);
		case (op)
			OP_ADD:  return d + c;
			OP_MAX:  return (d > c) ? d : c;
			default: return d;
		endcase
	endfunction

	assign o_ag_ack     = i_ag_rdy && (state == EMPTY);
	assign o_dramra_rdy = (state == REQ);
	// take the line only when the result slot is free or leaving
	assign o_dramrd_ack = i_dramrd_rdy && (state == WAIT) && (!o_alu_rdy || i_alu_ack);

	// masked-off lanes go out as zero
	always_comb begin
		for (int k = 0; k < CSIZE; k++)
			line[k*DBW +: DBW] = req_mask[k] ? lane_op(i_op, i_dramrd[k*DBW +: DBW], i_const) : '0;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= EMPTY;
			o_alu_rdy <= 1'b0;
		end else begin
			case (state)
				EMPTY:   if (o_ag_ack) state <= REQ;
				REQ:     if (i_dramra_ack) state <= WAIT;
				WAIT:    if (o_dramrd_ack) state <= EMPTY;
				default: state <= EMPTY;
			endcase
			if (o_dramrd_ack)
				o_alu_rdy <= 1'b1;
			else if (i_alu_ack)
				o_alu_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_ag_ack) begin
			o_dramra  <= i_raddr;
			req_waddr <= i_waddr;
			req_mask  <= i_mask;
		end
		if (o_dramrd_ack) begin
			o_waddr <= req_waddr;
			o_wmask <= req_mask;
			o_wdata <= line;
		end
	end

endmodule

/* rtl/tile_writeback.sv */
// tile masked line write-back
module tile_writeback (
	input  logic                                   i_clk,
	input  logic                                   i_arst_n,
	input  logic                                   i_alu_rdy,
	output logic                                   o_alu_ack,
	input  logic [tau_pkg::GBW-1:0]                i_waddr,
	input  logic [tau_pkg::CSIZE*tau_pkg::DBW-1:0] i_wdata,
	input  logic [tau_pkg::CSIZE-1:0]              i_wmask,
	output logic                                   o_dramw_rdy,
	input  logic                                   i_dramw_ack,
	output logic [tau_pkg::GBW-1:0]                o_dramwa,
	output logic [tau_pkg::CSIZE*tau_pkg::DBW-1:0] o_dramwd,
	output logic [tau_pkg::CSIZE-1:0]              o_dramw_mask,
	output logic                                   o_blkdone
);

	logic w_fire; // write taken by dram

	assign w_fire = o_dramw_rdy && i_dramw_ack;

	// refill while the current write leaves
	assign o_alu_ack = i_alu_rdy && (!o_dramw_rdy || w_fire);

	// ==================================================
	// control
	// ==================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_dramw_rdy <= 1'b0;
			o_blkdone   <= 1'b0;
		end else begin
			if (o_alu_ack)
				o_dramw_rdy <= 1'b1;
			else if (w_fire)
				o_dramw_rdy <= 1'b0;
			o_blkdone <= w_fire; // one pulse per block, the cycle after ack
		end
	end

	// ==================================================
	// line register
	// ==================================================
	always_ff @(posedge i_clk) begin
		if (o_alu_ack) begin
			o_dramwa     <= i_waddr;
			o_dramwd     <= i_wdata;
			o_dramw_mask <= i_wmask;
		end
	end

endmodule

/* rtl/tile_accum_unit.sv */
// tile accumulation unit
module tile_accum_unit (
	input  logic                                   i_clk,
	input  logic                                   i_arst_n,
	input  logic                                   i_bofs_rdy,
	output logic                                   o_bofs_ack,
	input  logic [tau_pkg::WBW-1:0]                i_bofs_x,
	input  logic [tau_pkg::WBW-1:0]                i_bofs_y,
	input  logic [tau_pkg::WBW-1:0]                i_bboundary_x,
	input  logic [tau_pkg::GBW-1:0]                i_in_base,
	input  logic [tau_pkg::GBW-1:0]                i_out_base,
	input  logic [tau_pkg::GBW-1:0]                i_row_pitch,
	input  tau_pkg::op_e                           i_op,
	input  logic [tau_pkg::DBW-1:0]                i_const,
	output logic                                   o_dramra_rdy,
	input  logic                                   i_dramra_ack,
	output logic [tau_pkg::GBW-1:0]                o_dramra,
	input  logic                                   i_dramrd_rdy,
	output logic                                   o_dramrd_ack,
	input  logic [tau_pkg::CSIZE*tau_pkg::DBW-1:0] i_dramrd,
	output logic                                   o_dramw_rdy,
	input  logic                                   i_dramw_ack,
	output logic [tau_pkg::GBW-1:0]                o_dramwa,
	output logic [tau_pkg::CSIZE*tau_pkg::DBW-1:0] o_dramwd,
	output logic [tau_pkg::CSIZE-1:0]              o_dramw_mask,
	output logic                                   o_blkdone
);
	import tau_pkg::*;

	// addr_gen -> alu
	logic                 ag_rdy, ag_ack;
	logic [GBW-1:0]       ag_raddr, ag_waddr;
	logic [CSIZE-1:0]     ag_mask;
	// alu -> write-back
	logic                 alu_rdy, alu_ack;
	logic [GBW-1:0]       alu_waddr;
	logic [CSIZE*DBW-1:0] alu_wdata;
	logic [CSIZE-1:0]     alu_wmask;

	tile_addr_gen u_ag (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_bofs_rdy(i_bofs_rdy), .o_bofs_ack(o_bofs_ack),
		.i_bofs_x(i_bofs_x), .i_bofs_y(i_bofs_y),
		.i_bboundary_x(i_bboundary_x), .i_in_base(i_in_base),
		.i_out_base(i_out_base), .i_row_pitch(i_row_pitch),
		.o_ag_rdy(ag_rdy), .i_ag_ack(ag_ack),
		.o_raddr(ag_raddr), .o_waddr(ag_waddr), .o_mask(ag_mask)
	);

	tile_alu u_alu (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_ag_rdy(ag_rdy), .o_ag_ack(ag_ack),
		.i_raddr(ag_raddr), .i_waddr(ag_waddr), .i_mask(ag_mask),
		.i_op(i_op), .i_const(i_const),
		.o_dramra_rdy(o_dramra_rdy), .i_dramra_ack(i_dramra_ack), .o_dramra(o_dramra),
		.i_dramrd_rdy(i_dramrd_rdy), .o_dramrd_ack(o_dramrd_ack), .i_dramrd(i_dramrd),
		.o_alu_rdy(alu_rdy), .i_alu_ack(alu_ack),
		.o_waddr(alu_waddr), .o_wdata(alu_wdata), .o_wmask(alu_wmask)
	);

	tile_writeback u_wb (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_alu_rdy(alu_rdy), .o_alu_ack(alu_ack),
		.i_waddr(alu_waddr), .i_wdata(alu_wdata), .i_wmask(alu_wmask),
		.o_dramw_rdy(o_dramw_rdy), .i_dramw_ack(i_dramw_ack),
		.o_dramwa(o_dramwa), .o_dramwd(o_dramwd), .o_dramw_mask(o_dramw_mask),
		.o_blkdone(o_blkdone)
	);

endmodule

/* rtl/tau_top.sv */
// tile accelerator top level
module tau_top #(
	parameter int N_TAU = tau_pkg::N_TAU_DEF
) (
	input  logic                                              i_clk,
	input  logic                                              i_arst_n,
	// job start
	input  logic                                              i_src_rdy,
	output logic                                              o_src_ack,
	input  logic [tau_pkg::WBW-1:0]                           i_bgrid_step [tau_pkg::VDIM],
	input  logic [tau_pkg::WBW-1:0]                           i_bgrid_end  [tau_pkg::VDIM],
	input  logic [tau_pkg::WBW-1:0]                           i_bboundary_x,
	input  logic [tau_pkg::GBW-1:0]                           i_in_base,
	input  logic [tau_pkg::GBW-1:0]                           i_out_base,
	input  logic [tau_pkg::GBW-1:0]                           i_row_pitch,
	input  tau_pkg::op_e                                      i_op,
	input  logic [tau_pkg::DBW-1:0]                           i_const,
	output logic                                              o_job_done,
	// per-tile dram channels
	output logic [N_TAU-1:0]                                  o_dramra_rdy,
	input  logic [N_TAU-1:0]                                  i_dramra_ack,
	output logic [N_TAU-1:0][tau_pkg::GBW-1:0]                o_dramras,
	input  logic [N_TAU-1:0]                                  i_dramrd_rdy,
	output logic [N_TAU-1:0]                                  o_dramrd_ack,
	input  logic [N_TAU-1:0][tau_pkg::CSIZE*tau_pkg::DBW-1:0] i_dramrds,
	output logic [N_TAU-1:0]                                  o_dramw_rdy,
	input  logic [N_TAU-1:0]                                  i_dramw_ack,
	output logic [N_TAU-1:0][tau_pkg::GBW-1:0]                o_dramwas,
	output logic [N_TAU-1:0][tau_pkg::CSIZE*tau_pkg::DBW-1:0] o_dramwds,
	output logic [N_TAU-1:0][tau_pkg::CSIZE-1:0]              o_dramw_masks
);
	import tau_pkg::*;

	logic [N_TAU-1:0] bofs_rdy, bofs_ack, blkdone;
	logic [WBW-1:0]   bofs_x, bofs_y;  // shared by all tiles

	block_looper #(.N_TAU(N_TAU)) u_looper (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_src_rdy(i_src_rdy), .o_src_ack(o_src_ack),
		.i_bgrid_step(i_bgrid_step), .i_bgrid_end(i_bgrid_end),
		.o_bofs_rdy(bofs_rdy), .i_bofs_ack(bofs_ack),
		.o_bofs_x(bofs_x), .o_bofs_y(bofs_y),
		.i_blkdone(blkdone), .o_job_done(o_job_done)
	);

	// ==================================================
	// tile array
	// ==================================================
	for (genvar t = 0; t < N_TAU; t++) begin : g_tau
		tile_accum_unit u_tau (
			.i_clk(i_clk), .i_arst_n(i_arst_n),
			.i_bofs_rdy(bofs_rdy[t]), .o_bofs_ack(bofs_ack[t]),
			.i_bofs_x(bofs_x), .i_bofs_y(bofs_y),
			.i_bboundary_x(i_bboundary_x), .i_in_base(i_in_base),
			.i_out_base(i_out_base), .i_row_pitch(i_row_pitch),
			.i_op(i_op), .i_const(i_const),
			.o_dramra_rdy(o_dramra_rdy[t]), .i_dramra_ack(i_dramra_ack[t]),
			.o_dramra(o_dramras[t]),
			.i_dramrd_rdy(i_dramrd_rdy[t]), .o_dramrd_ack(o_dramrd_ack[t]),
			.i_dramrd(i_dramrds[t]),
			.o_dramw_rdy(o_dramw_rdy[t]), .i_dramw_ack(i_dramw_ack[t]),
			.o_dramwa(o_dramwas[t]), .o_dramwd(o_dramwds[t]),
			.o_dramw_mask(o_dramw_masks[t]),
			.o_blkdone(blkdone[t])
		);
	end

endmodule

/* tests/tb_clock.sv */
// testbench clock and reset
module tb_clock #(
	parameter int PERIOD     = 100,
	parameter int RST_CYCLES = 2
) (
	output logic o_clk,
	output logic o_arst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD/2) o_clk = ~o_clk;
	end

	// reset leaves on a falling edge
	initial begin
		o_arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_arst_n = 1'b1;
	end

endmodule

/* tests/tb_dram_model.sv */
// dram channel responder
module tb_dram_model (
	input  logic                                   i_clk,
	input  logic                                   i_arst_n,
	input  logic                                   i_ra_rdy,
	output logic                                   o_ra_ack,
	input  logic [tau_pkg::GBW-1:0]                i_ra,
	output logic                                   o_rd_rdy,
	input  logic                                   i_rd_ack,
	output logic [tau_pkg::CSIZE*tau_pkg::DBW-1:0] o_rd,
	input  logic                                   i_w_rdy,
	output logic                                   o_w_ack
);
	import tau_pkg::*;

	// memory content is a pattern of the word address
	function automatic logic [DBW-1:0] model_word(logic [GBW-1:0] a, int k);
		logic [DBW-1:0] s;
		s = a + DBW'(k);
		return (s * 16'h9e37) ^ 16'h5a5a;
	endfunction

	initial begin
		logic           ra_fire;
		logic           rd_fire;
		logic           busy;
		logic [GBW-1:0] addr;
		int             delay;
		o_ra_ack = 1'b0;
		o_rd_rdy = 1'b0;
		o_rd     = '0;
		o_w_ack  = 1'b0;
		busy     = 1'b0;
		delay    = 0;
		addr     = '0;
		forever begin
			@(posedge i_clk);
			ra_fire = i_arst_n && i_ra_rdy && o_ra_ack;
			rd_fire = i_arst_n && o_rd_rdy && i_rd_ack;
			if (ra_fire)
				addr = i_ra;
			@(negedge i_clk);
			if (rd_fire)
				o_rd_rdy = 1'b0;
			if (ra_fire) begin
				busy  = 1'b1;
				delay = int'($urandom % 4); // read latency 0 to 3 cycles
			end
			if (busy && !o_rd_rdy) begin
				if (delay == 0) begin
					for (int k = 0; k < CSIZE; k++)
						o_rd[k*DBW +: DBW] = model_word(addr, k);
					o_rd_rdy = 1'b1;
					busy     = 1'b0;
				end else begin
					delay--;
				end
			end
			o_ra_ack = !busy && !o_rd_rdy && ($urandom % 4 != 0); // random stalls
			o_w_ack  = i_w_rdy && ($urandom % 3 != 0);
		end
	end

endmodule

/* tests/tb_top.sv */
// tile accelerator testbench
module tb_top;
	import tau_pkg::*;

	localparam int N_TAU  = N_TAU_DEF;
	localparam int N_JOBS = 3;

	// ==================================================
	// job table
	// ==================================================
	localparam int  STEP_X [N_JOBS] = '{4, 4, 4};
	localparam int  STEP_Y [N_JOBS] = '{1, 2, 1};
	localparam int  END_X  [N_JOBS] = '{16, 10, 8};
	localparam int  END_Y  [N_JOBS] = '{3, 6, 4};
	localparam int  BOUND  [N_JOBS] = '{14, 10, 8};     // first two cut the last x block
	localparam int  IN_B   [N_JOBS] = '{'h1000, 'h2345, 'h0100};
	localparam int  OUT_B  [N_JOBS] = '{'h8000, 'h9000, 'ha000};
	localparam int  PITCH  [N_JOBS] = '{32, 20, 16};
	localparam op_e JOB_OP [N_JOBS] = '{OP_PASS, OP_ADD, OP_MAX};
	localparam int  CONST  [N_JOBS] = '{'h0000, 'h1234, 'h8000};

	function automatic int timeout_limit();
		int sum;
		sum = 0;
		for (int j = 0; j < N_JOBS; j++)
			sum += ((END_X[j] + STEP_X[j] - 1) / STEP_X[j])
				* ((END_Y[j] + STEP_Y[j] - 1) / STEP_Y[j]) * 40;
		return sum + 200;
	endfunction

	localparam int TIMEOUT = timeout_limit();

	logic clk, arst_n;
	logic                 src_rdy, src_ack, job_done;
	logic [WBW-1:0]       bgrid_step [VDIM];
	logic [WBW-1:0]       bgrid_end  [VDIM];
	logic [WBW-1:0]       bboundary_x;
	logic [GBW-1:0]       in_base, out_base, row_pitch;
	op_e                  op;
	logic [DBW-1:0]       cst;
	logic [N_TAU-1:0]     ra_rdy, ra_ack, rd_rdy, rd_ack, w_rdy, w_ack, w_fire;
	logic [N_TAU-1:0][GBW-1:0]       ras, was;
	logic [N_TAU-1:0][CSIZE*DBW-1:0] rds, wds;
	logic [N_TAU-1:0][CSIZE-1:0]     wmasks;
	logic                 started;     // first job offered
	logic                 job_active;  // between job accept and done
	logic [7:0]           wr_count [65536];
	int                   cycles;

	tb_clock #(.PERIOD(100), .RST_CYCLES(2)) u_clk (.o_clk(clk), .o_arst_n(arst_n));

	tau_top #(.N_TAU(N_TAU)) i_tau_top (
		.i_clk(clk), .i_arst_n(arst_n),
		.i_src_rdy(src_rdy), .o_src_ack(src_ack),
		.i_bgrid_step(bgrid_step), .i_bgrid_end(bgrid_end),
		.i_bboundary_x(bboundary_x), .i_in_base(in_base),
		.i_out_base(out_base), .i_row_pitch(row_pitch),
		.i_op(op), .i_const(cst), .o_job_done(job_done),
		.o_dramra_rdy(ra_rdy), .i_dramra_ack(ra_ack), .o_dramras(ras),
		.i_dramrd_rdy(rd_rdy), .o_dramrd_ack(rd_ack), .i_dramrds(rds),
		.o_dramw_rdy(w_rdy), .i_dramw_ack(w_ack), .o_dramwas(was),
		.o_dramwds(wds), .o_dramw_masks(wmasks)
	);

	for (genvar t = 0; t < N_TAU; t++) begin : g_dram
		tb_dram_model u_dram (
			.i_clk(clk), .i_arst_n(arst_n),
			.i_ra_rdy(ra_rdy[t]), .o_ra_ack(ra_ack[t]), .i_ra(ras[t]),
			.o_rd_rdy(rd_rdy[t]), .i_rd_ack(rd_ack[t]), .o_rd(rds[t]),
			.i_w_rdy(w_rdy[t]), .o_w_ack(w_ack[t])
		);
	end

	assign w_fire = w_rdy & w_ack;

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// ==================================================
	// reference model
	// ==================================================
	function automatic logic [DBW-1:0] source_word(logic [GBW-1:0] a, int k);
		logic [DBW-1:0] s;
		s = a + DBW'(k);
		return (s * 16'h9e37) ^ 16'h5a5a;
	endfunction

	function automatic logic [DBW-1:0] apply_op(op_e o, logic [DBW-1:0] d, logic [DBW-1:0] c);
		if (o == OP_ADD)
			return d + c;
		if (o == OP_MAX)
			return (d > c) ? d : c;
		return d;
	endfunction

	function automatic logic [CSIZE-1:0] expected_mask(logic [GBW-1:0] wa);
		logic [GBW-1:0]   off;
		logic [CSIZE-1:0] m;
		int               x;
		off = wa - out_base;
		x   = int'(off % row_pitch);
		for (int k = 0; k < CSIZE; k++)
			m[k] = (x + k) < int'(bboundary_x);
		return m;
	endfunction

	function automatic logic [CSIZE*DBW-1:0] expected_line(logic [GBW-1:0] wa);
		logic [GBW-1:0]       ra;
		logic [CSIZE-1:0]     m;
		logic [CSIZE*DBW-1:0] line;
		ra = in_base + (wa - out_base);  // same offset in the input region
		m  = expected_mask(wa);
		for (int k = 0; k < CSIZE; k++)
			line[k*DBW +: DBW] = m[k] ? apply_op(op, source_word(ra, k), cst) : '0;
		return line;
	endfunction

	function automatic bit on_grid(logic [GBW-1:0] wa);
		logic [GBW-1:0] off;
		int             x, y;
		off = wa - out_base;
		x   = int'(off % row_pitch);
		y   = int'(off / row_pitch);
		return x < int'(bgrid_end[0]) && x % int'(bgrid_step[0]) == 0
			&& y < int'(bgrid_end[1]) && y % int'(bgrid_step[1]) == 0;
	endfunction

	// another tile writing the same line in the same cycle
	function automatic bit same_cycle_dup(int t, logic [N_TAU-1:0] fire,
			logic [N_TAU-1:0][GBW-1:0] wa);
		for (int u = 0; u < t; u++)
			if (fire[u] && wa[u] == wa[t])
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic bit grid_written_once();
		logic [GBW-1:0] a;
		bit             ok;
		ok = 1'b1;
		for (int y = 0; y < int'(bgrid_end[1]); y += int'(bgrid_step[1]))
			for (int x = 0; x < int'(bgrid_end[0]); x += int'(bgrid_step[0])) begin
				a = out_base + GBW'(y) * row_pitch + GBW'(x);
				if (wr_count[a] != 8'd1)
					ok = 1'b0;
			end
		return ok;
	endfunction

	// ==================================================
	// scoreboard state
	// ==================================================
	always @(posedge clk) begin
		if (!arst_n) begin
			for (int i = 0; i < 65536; i++)
				wr_count[i] <= 8'd0;  // cleared while reset is held
		end else begin
			for (int t = 0; t < N_TAU; t++)
				if (w_fire[t])
					wr_count[was[t]] <= wr_count[was[t]] + 8'd1;
		end
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			job_active <= 1'b0;
		else if (src_rdy && src_ack)
			job_active <= 1'b1;
		else if (job_done)
			job_active <= 1'b0;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
			stop_on_error($sformatf("timeout: job not done after %0d cycles", cycles));
	end

	// ==================================================
	// assertions
	// ==================================================
	assert property (@(posedge clk) disable iff (!arst_n)
		!started |-> !(|ra_rdy) && !(|rd_ack) && !(|w_rdy) && !src_ack && !job_done)
		else stop_on_error("dut became active before the first job was offered");

	assert property (@(posedge clk) disable iff (!arst_n) job_done |-> job_active)
		else stop_on_error("o_job_done pulsed without an active job");

	assert property (@(posedge clk) disable iff (!arst_n) job_done |-> grid_written_once())
		else stop_on_error("job done but some grid offset was not written exactly once");

	for (genvar t = 0; t < N_TAU; t++) begin : g_chk
		assert property (@(posedge clk) disable iff (!arst_n) w_fire[t] |-> job_active)
			else stop_on_error($sformatf("write on tile %0d outside a job", t));

		assert property (@(posedge clk) disable iff (!arst_n)
			w_fire[t] |-> on_grid(was[t]) && wr_count[was[t]] == 8'd0
				&& !same_cycle_dup(t, w_fire, was))
			else stop_on_error($sformatf("error at %0t: o_dramwas[%0d] = %h is off grid or repeated",
				$time, t, $sampled(was[t])));

		assert property (@(posedge clk) disable iff (!arst_n)
			w_fire[t] |-> wmasks[t] == expected_mask(was[t]))
			else stop_on_error($sformatf("error at %0t: o_dramw_masks[%0d] = %b, expected %b",
				$time, t, $sampled(wmasks[t]), expected_mask($sampled(was[t]))));

		assert property (@(posedge clk) disable iff (!arst_n)
			w_fire[t] |-> wds[t] == expected_line(was[t]))
			else stop_on_error($sformatf("error at %0t: o_dramwds[%0d] = %h, expected %h",
				$time, t, $sampled(wds[t]), expected_line($sampled(was[t]))));

		// rdy and data hold until ack
		assert property (@(posedge clk) disable iff (!arst_n)
			ra_rdy[t] && !ra_ack[t] |=> ra_rdy[t] && $stable(ras[t]))
			else stop_on_error($sformatf("read address on tile %0d changed before ack", t));

		assert property (@(posedge clk) disable iff (!arst_n)
			w_rdy[t] && !w_ack[t] |=> w_rdy[t] && $stable(was[t]) && $stable(wds[t])
				&& $stable(wmasks[t]))
			else stop_on_error($sformatf("write on tile %0d changed before ack", t));
	end

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		void'($urandom(32'h40ff9ed5));
		started       = 1'b0;
		src_rdy       = 1'b0;
		bgrid_step[0] = '0;
		bgrid_step[1] = '0;
		bgrid_end[0]  = '0;
		bgrid_end[1]  = '0;
		bboundary_x   = '0;
		in_base       = '0;
		out_base      = '0;
		row_pitch     = '0;
		op            = OP_PASS;
		cst           = '0;
		@(posedge arst_n);
		repeat (3) @(negedge clk);  // idle window for the reset check
		for (int j = 0; j < N_JOBS; j++) begin
			@(negedge clk);
			bgrid_step[0] = WBW'(STEP_X[j]);
			bgrid_step[1] = WBW'(STEP_Y[j]);
			bgrid_end[0]  = WBW'(END_X[j]);
			bgrid_end[1]  = WBW'(END_Y[j]);
			bboundary_x   = WBW'(BOUND[j]);
			in_base       = GBW'(IN_B[j]);
			out_base      = GBW'(OUT_B[j]);
			row_pitch     = GBW'(PITCH[j]);
			op            = JOB_OP[j];
			cst           = DBW'(CONST[j]);
			src_rdy       = 1'b1;
			started       = 1'b1;
			do @(posedge clk); while (!src_ack);
			@(negedge clk);
			src_rdy = 1'b0;
			do @(posedge clk); while (!job_done);
			repeat (5) @(negedge clk);  // quiet gap where a late write would be caught
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* all.f */
rtl/tau_pkg.sv
rtl/block_looper.sv
rtl/tile_addr_gen.sv
rtl/tile_alu.sv
rtl/tile_writeback.sv
rtl/tile_accum_unit.sv
rtl/tau_top.sv
tests/tb_clock.sv
tests/tb_dram_model.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f all.f -o sim_tb \
	|| { echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
